//--- rtl/hazardPkg.sv
// shared types for the hazard slice of the RV32I pipeline
// holds the instruction packet, the decoded control bits and the decoder
`default_nettype none

package hazardPkg;

	// one trace entry as it travels from the fetch source to retire
	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		// resolved outcome of a branch or jump, taken from the trace
		logic taken;
	} instrPacket;

	// control fields that the hazard checkers compare
	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic isBranch;
		logic isJump;
		logic isEcall;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
	} ctrlBits;

	// contents of one pipeline stage register
	typedef struct packed {
		logic valid;
		instrPacket pkt;
		ctrlBits ctrl;
	} stageSlot;

	localparam logic [6:0] opLoad = 7'b0000011;
	localparam logic [6:0] opStore = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opSystem = 7'b1110011;

	// a source the instruction does not read is returned as x0
	// so the checkers never match on a field that is really an immediate
	function automatic ctrlBits decodeCtrl(input logic [31:0] instr);
		ctrlBits c;
		logic [6:0] opcode;
		logic isJal;
		logic isJalr;
		logic isSystem;
		logic noDest;
		opcode = instr[6:0];
		isJal = (opcode == opJal);
		isJalr = (opcode == opJalr);
		isSystem = (opcode == opSystem);
		// stores, branches and system instructions have no destination
		noDest = (opcode == opStore) || (opcode == opBranch) || isSystem;
		c.rd = instr[11:7];
		// writes to x0 are discarded by the register file, so they count as none
		c.regWrite = !noDest && (c.rd != 5'd0);
		c.memRead = (opcode == opLoad);
		c.isBranch = (opcode == opBranch);
		c.isJump = isJal || isJalr;
		c.isEcall = isSystem && (instr[31:7] == 25'd0);
		c.rs1 = (isJal || isSystem) ? 5'd0 : instr[19:15];
		// bit 5 of the opcode separates stores, R-type and branches from the
		// load and immediate formats, which carry an immediate where rs2 would be
		c.rs2 = (opcode[5] && !c.isJump && !isSystem) ? instr[24:20] : 5'd0;
		return c;
	endfunction

endpackage

`default_nettype wire

//--- rtl/loadUseCheck.sv
// load-to-use checker
// flags a load in decode whose result the instruction in fetch needs
`timescale 1ns/1ns
`default_nettype none

module loadUseCheck (
	// instruction sitting at the head of the fetch buffer
	input wire hazardPkg::ctrlBits fetchCtrl,
	// instruction held in the IF/ID register
	input wire hazardPkg::ctrlBits decodeCtrl,
	input wire logic decodeValid,
	output logic stall
);

	logic decodeIsLoad;
	logic rs1Match;
	logic rs2Match;

	// the load data only exists after MEM, one cycle too late for a consumer
	// entering decode right behind it
	assign decodeIsLoad = decodeValid && decodeCtrl.memRead && decodeCtrl.regWrite;

	// unused sources come out of the decoder as x0
	// a load to x0 has regWrite low, so x0 never produces a match here
	assign rs1Match = (decodeCtrl.rd == fetchCtrl.rs1);
	assign rs2Match = (decodeCtrl.rd == fetchCtrl.rs2);

	// one bubble is enough since the load moves on to ID/EX next cycle
	// and forwarding covers the consumer from there
	assign stall = decodeIsLoad && (rs1Match || rs2Match);

endmodule

`default_nettype wire

//--- rtl/controlUseCheck.sv
// control-to-use checker
// flags a branch or jalr in fetch whose operand is still being produced downstream
`timescale 1ns/1ns
`default_nettype none

module controlUseCheck #(
	// 0 matches any producer that writes a register, 1 only loads
	parameter bit LoadOnly = 1'b0
) (
	input wire hazardPkg::ctrlBits fetchCtrl,
	// producer further down the pipeline
	input wire hazardPkg::ctrlBits downCtrl,
	input wire logic downValid,
	output logic stall
);

	logic fetchIsControl;
	logic producerWrites;
	logic producerKind;
	logic srcMatch;

	// branches compare in decode, so their operands are needed earlier
	// than an ALU consumer's
	// jal is covered too, but its sources are x0 and never match
	assign fetchIsControl = fetchCtrl.isBranch || fetchCtrl.isJump;

	// a write to x0 already has regWrite low from the decoder
	assign producerWrites = downValid && downCtrl.regWrite;

	// with LoadOnly clear every writer counts, otherwise only a load does
	assign producerKind = !LoadOnly || downCtrl.memRead;

	assign srcMatch = (downCtrl.rd == fetchCtrl.rs1) || (downCtrl.rd == fetchCtrl.rs2);

	// the ALU instance looks at IF/ID and costs one bubble
	// the load instance looks at ID/EX and extends a load stall to two
	assign stall = fetchIsControl && producerWrites && producerKind && srcMatch;

endmodule

`default_nettype wire

//--- rtl/hazardDetection.sv
// hazard detection for the fetch slot
// merges the RAW checkers, resolves mispredictions and holds the ecall halt
`timescale 1ns/1ns
`default_nettype none

module hazardDetection (
	input wire logic clk,
	input wire logic rst,
	input wire hazardPkg::ctrlBits fetchCtrl,
	input wire hazardPkg::ctrlBits decodeCtrl,
	input wire hazardPkg::ctrlBits execCtrl,
	input wire logic headValid,
	input wire logic decodeValid,
	input wire logic execValid,
	input wire logic decodeTaken,
	output logic fetchEnable,
	output logic squashFetch,
	output logic mispredict,
	output logic halted
);

	logic stallLoadUse;
	logic stallAluBranch;
	logic stallLoadBranch;
	logic stall;
	logic ecallInDecode;
	logic haltReg;
	logic squashPending;
	logic holdFetch;

	loadUseCheck uLoadUse (
		.fetchCtrl(fetchCtrl),
		.decodeCtrl(decodeCtrl),
		.decodeValid(decodeValid),
		.stall(stallLoadUse)
	);

	// writer in IF/ID feeding a branch in fetch
	controlUseCheck #(.LoadOnly(1'b0)) uAluBranch (
		.fetchCtrl(fetchCtrl),
		.downCtrl(decodeCtrl),
		.downValid(decodeValid),
		.stall(stallAluBranch)
	);

	// load in ID/EX feeding a branch in fetch
	controlUseCheck #(.LoadOnly(1'b1)) uLoadBranch (
		.fetchCtrl(fetchCtrl),
		.downCtrl(execCtrl),
		.downValid(execValid),
		.stall(stallLoadBranch)
	);

	// an empty slot has nothing to hold back
	assign stall = headValid && (stallLoadUse || stallAluBranch || stallLoadBranch);

	// fetch always predicts not taken, so any taken control flow in decode
	// means the next packet is on the wrong path
	assign mispredict = decodeValid && (decodeCtrl.isBranch || decodeCtrl.isJump) && decodeTaken;

	// if the wrong-path packet has not arrived yet, the squash waits for it
	assign squashFetch = headValid && (mispredict || squashPending);

	assign ecallInDecode = decodeValid && decodeCtrl.isEcall;
	assign halted = haltReg || ecallInDecode;

	// a squash takes the slot even when a checker fires on the dead packet
	assign holdFetch = halted || (stall && !squashFetch);
	assign fetchEnable = !holdFetch;

	always_ff @(posedge clk) begin
		if (rst) begin
			haltReg <= 1'b0;
			squashPending <= 1'b0;
		end else begin
			// sticky until reset, nothing after the ecall is fetched
			if (ecallInDecode) begin
				haltReg <= 1'b1;
			end
			if (squashFetch) begin
				squashPending <= 1'b0;
			end else if (mispredict) begin
				squashPending <= 1'b1;
			end
		end
	end

	// a squash pops the head, which a halt would have frozen
	assert property (@(posedge clk) disable iff (rst) squashFetch |-> !holdFetch);

	// the slot behind a redirected branch always becomes a bubble in IF/ID
	assert property (@(posedge clk) disable iff (rst) mispredict |=> !mispredict);

endmodule

`default_nettype wire

//--- rtl/fetchBuffer.sv
// credit-managed fetch FIFO
// accepts packets from the trace source and presents the oldest one as the fetch slot
`timescale 1ns/1ns
`default_nettype none

module fetchBuffer #(
	// depth equals the number of credits the source starts with
	parameter int FetchDepth = 4,
	parameter type payloadT = logic [31:0]
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic inValid,
	input wire payloadT inData,
	input wire logic pop,
	output logic headValid,
	output payloadT headData,
	output logic creditReturn
);

	localparam int PtrW = (FetchDepth > 1) ? $clog2(FetchDepth) : 1;
	localparam int CntW = $clog2(FetchDepth + 1);

	payloadT mem [FetchDepth];
	logic [PtrW-1:0] wrPtr;
	logic [PtrW-1:0] rdPtr;
	logic [CntW-1:0] count;

	// wraps at FetchDepth so the depth need not be a power of two
	function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] p);
		return (p == PtrW'(FetchDepth - 1)) ? '0 : p + PtrW'(1);
	endfunction

	// a packet written on one edge is the head right after it
	assign headValid = (count != '0);
	assign headData = mem[rdPtr];

	always_ff @(posedge clk) begin
		if (inValid) begin
			mem[wrPtr] <= inData;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			creditReturn <= 1'b0;
		end else begin
			if (inValid) begin
				wrPtr <= nextPtr(wrPtr);
			end
			if (pop) begin
				rdPtr <= nextPtr(rdPtr);
			end
			case ({inValid, pop})
				2'b10: count <= count + CntW'(1);
				2'b01: count <= count - CntW'(1);
				default: count <= count;
			endcase
			// the credit goes back one cycle after the entry is freed
			creditReturn <= pop;
		end
	end

	// the source only sends while it holds a credit, so a full buffer sees no push
	assert property (@(posedge clk) disable iff (rst) inValid |-> (count != CntW'(FetchDepth)));

	// both the advance into IF/ID and the squash need a packet at the head
	assert property (@(posedge clk) disable iff (rst) pop |-> headValid);

endmodule

`default_nettype wire

//--- rtl/pipelineTrack.sv
// IF/ID, ID/EX, EX/MEM and MEM/WB stage registers
// decodes the fetch slot and moves packets toward retire, inserting bubbles
`timescale 1ns/1ns
`default_nettype none

module pipelineTrack (
	input wire logic clk,
	input wire logic rst,
	input wire logic headValid,
	input wire hazardPkg::instrPacket headPacket,
	input wire logic fetchEnable,
	input wire logic squashFetch,
	output logic popHead,
	output hazardPkg::ctrlBits fetchCtrl,
	output hazardPkg::ctrlBits decodeCtrl,
	output hazardPkg::ctrlBits execCtrl,
	output logic decodeValid,
	output logic execValid,
	output logic decodeTaken,
	output logic retireValid,
	output hazardPkg::instrPacket retirePacket
);

	import hazardPkg::*;

	stageSlot ifId;
	stageSlot idEx;
	stageSlot exMem;
	stageSlot memWb;
	ctrlBits headCtrl;
	logic enterDecode;

	// the port named decodeCtrl hides the package function, hence the scoped call
	assign headCtrl = hazardPkg::decodeCtrl(headPacket.instr);
	assign fetchCtrl = headCtrl;

	// the head moves into IF/ID only when it is live and nothing holds it
	assign enterDecode = headValid && fetchEnable && !squashFetch;

	// a squashed packet leaves the buffer without entering IF/ID
	assign popHead = squashFetch || (fetchEnable && headValid);

	always_ff @(posedge clk) begin
		if (rst) begin
			ifId.valid <= 1'b0;
			idEx.valid <= 1'b0;
			exMem.valid <= 1'b0;
			memWb.valid <= 1'b0;
		end else begin
			// a stall leaves the consumer in the fetch slot and sends a bubble on
			ifId.valid <= enterDecode;
			ifId.pkt <= headPacket;
			ifId.ctrl <= headCtrl;
			// the later stages never stall, so they shift on every edge
			idEx <= ifId;
			exMem <= idEx;
			memWb <= exMem;
		end
	end

	assign decodeCtrl = ifId.ctrl;
	assign decodeValid = ifId.valid;
	assign decodeTaken = ifId.pkt.taken;

	assign execCtrl = idEx.ctrl;
	assign execValid = idEx.valid;

	// retire is always accepted, MEM/WB drives it directly
	assign retireValid = memWb.valid;
	assign retirePacket = memWb.pkt;

	// nothing behind an ecall is fetched, so it is the last packet to retire
	assert property (@(posedge clk) disable iff (rst)
		(memWb.valid && memWb.ctrl.isEcall) |=> !memWb.valid);

endmodule

`default_nettype wire

//--- rtl/hazardTop.sv
// top of the pipeline hazard slice
// connects the fetch buffer, the stage registers and the hazard detection
`timescale 1ns/1ns
`default_nettype none

module hazardTop #(
	parameter int FetchDepth = 4
) (
	input wire logic clk,
	input wire logic rst,
	input wire logic inValid,
	input wire hazardPkg::instrPacket inPacket,
	output logic creditReturn,
	output logic retireValid,
	output hazardPkg::instrPacket retirePacket,
	output logic mispredict,
	output logic halted
);

	import hazardPkg::*;

	// fetch slot between the buffer and the pipeline
	logic headValid;
	instrPacket headPacket;
	logic popHead;

	// decoded view of the slot and the two stages behind it
	ctrlBits fetchCtrl;
	ctrlBits decodeCtrl;
	ctrlBits execCtrl;
	logic decodeValid;
	logic execValid;
	logic decodeTaken;

	logic fetchEnable;
	logic squashFetch;

	fetchBuffer #(
		.FetchDepth(FetchDepth),
		.payloadT(instrPacket)
	) uFetchBuffer (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inData(inPacket),
		.pop(popHead),
		.headValid(headValid),
		.headData(headPacket),
		.creditReturn(creditReturn)
	);

	pipelineTrack uPipelineTrack (
		.clk(clk),
		.rst(rst),
		.headValid(headValid),
		.headPacket(headPacket),
		.fetchEnable(fetchEnable),
		.squashFetch(squashFetch),
		.popHead(popHead),
		.fetchCtrl(fetchCtrl),
		.decodeCtrl(decodeCtrl),
		.execCtrl(execCtrl),
		.decodeValid(decodeValid),
		.execValid(execValid),
		.decodeTaken(decodeTaken),
		.retireValid(retireValid),
		.retirePacket(retirePacket)
	);

	hazardDetection uHazardDetection (
		.clk(clk),
		.rst(rst),
		.fetchCtrl(fetchCtrl),
		.decodeCtrl(decodeCtrl),
		.execCtrl(execCtrl),
		.headValid(headValid),
		.decodeValid(decodeValid),
		.execValid(execValid),
		.decodeTaken(decodeTaken),
		.fetchEnable(fetchEnable),
		.squashFetch(squashFetch),
		.mispredict(mispredict),
		.halted(halted)
	);

endmodule

`default_nettype wire

//--- verif/clockGen.sv
// testbench clock and reset
// 40 ns clock, reset held high over the first three rising edges
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
	parameter int HalfPeriod = 20,
	parameter int ResetCycles = 3
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(HalfPeriod) clk = ~clk;
	end

	// released on the last reset edge, after the DUT has sampled it high
	initial begin
		rst = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

//--- verif/tbHazard.sv
// testbench for the pipeline hazard slice
// random trace with credit flow control, checked against an in-order retire model
`timescale 1ns/1ns
`default_nettype none

module tbHazard;

	import hazardPkg::*;

	localparam int FetchDepth = 4;
	localparam int TraceLen = 300;
	localparam int QuietCycles = 20;
	localparam int CycleLimit = 8 * TraceLen + 100;

	logic clk;
	logic rst;
	logic inValid;
	instrPacket inPacket;
	logic creditReturn;
	logic retireValid;
	instrPacket retirePacket;
	logic mispredict;
	logic halted;

	// the trace plus the register use the model derives while building it
	// a destination of 0 means the instruction writes nothing
	instrPacket trace [TraceLen];
	logic [4:0] traceRd [TraceLen];
	logic [4:0] traceSrc1 [TraceLen];
	logic [4:0] traceSrc2 [TraceLen];
	logic traceLoad [TraceLen];
	int retireCycle [TraceLen];
	// trace indices in the order they must retire
	int expected [$];
	int expectedRedirects;

	logic [31:0] lcgState;
	int credits;
	int sent;
	int returned;
	int retired;
	int redirects;
	int cycle;
	int ecallCycle;

	clockGen uClockGen (
		.clk(clk),
		.rst(rst)
	);

	hazardTop #(.FetchDepth(FetchDepth)) dut (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.inPacket(inPacket),
		.creditReturn(creditReturn),
		.retireValid(retireValid),
		.retirePacket(retirePacket),
		.mispredict(mispredict),
		.halted(halted)
	);

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// the low bits of an LCG cycle quickly, so draw from the upper half
	function automatic int randBelow(input int n);
		return int'((lcgNext() >> 16) % n);
	endfunction

	task automatic failNow(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic buildTrace();
		int kind;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		for (int i = 0; i < TraceLen; i++) begin
			// only x0 to x7, so producers and consumers collide often
			rd = 5'(randBelow(8));
			rs1 = 5'(randBelow(8));
			rs2 = 5'(randBelow(8));
			kind = randBelow(8);
			// the slot before the ecall must not redirect, or the ecall itself is squashed
			if (i == TraceLen - 2) begin
				kind = 1;
			end else if (i == TraceLen - 1) begin
				kind = 8;
			end
			trace[i].pc = 32'(i * 4);
			trace[i].taken = 1'b0;
			traceRd[i] = 5'd0;
			traceSrc1[i] = 5'd0;
			traceSrc2[i] = 5'd0;
			traceLoad[i] = 1'b0;
			case (kind)
				0, 7: begin
					trace[i].instr = {12'(randBelow(64)), rs1, 3'b010, rd, opLoad};
					traceRd[i] = rd;
					traceSrc1[i] = rs1;
					traceLoad[i] = 1'b1;
				end
				1: begin
					trace[i].instr = {12'h001, rs1, 3'b000, rd, 7'b0010011};
					traceRd[i] = rd;
					traceSrc1[i] = rs1;
				end
				2: begin
					trace[i].instr = {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
					traceRd[i] = rd;
					traceSrc1[i] = rs1;
					traceSrc2[i] = rs2;
				end
				3: begin
					trace[i].instr = {7'b0, rs2, rs1, 3'b010, 5'b0, opStore};
					traceSrc1[i] = rs1;
					traceSrc2[i] = rs2;
				end
				4: begin
					trace[i].instr = {7'b0, rs2, rs1, 3'b000, 5'b01000, opBranch};
					traceSrc1[i] = rs1;
					traceSrc2[i] = rs2;
					trace[i].taken = (randBelow(2) == 1);
				end
				5: begin
					trace[i].instr = {20'h00800, rd, opJal};
					traceRd[i] = rd;
					trace[i].taken = 1'b1;
				end
				6: begin
					trace[i].instr = {12'h000, rs1, 3'b000, rd, opJalr};
					traceRd[i] = rd;
					traceSrc1[i] = rs1;
					trace[i].taken = 1'b1;
				end
				default: trace[i].instr = 32'h00000073;
			endcase
		end
	endtask

	// not-taken prediction, so the packet right behind a taken branch or jump dies
	// a dead packet never reaches decode and cannot redirect anything itself
	task automatic buildExpected();
		logic skipNext;
		skipNext = 1'b0;
		expectedRedirects = 0;
		for (int i = 0; i < TraceLen; i++) begin
			if (skipNext) begin
				skipNext = 1'b0;
			end else begin
				expected.push_back(i);
				if (trace[i].taken) begin
					skipNext = 1'b1;
					expectedRedirects++;
				end
			end
		end
	endtask

	task automatic checkQuiet();
		assert (!retireValid && !creditReturn && !mispredict && !halted)
			else failNow($sformatf("outputs active around reset: retire %0b credit %0b %s %0b %0b",
				retireValid, creditReturn, "mispredict/halted", mispredict, halted));
	endtask

	task automatic checkRetire();
		int idx;
		assert (retired < expected.size())
			else failNow("a packet retired after every expected packet had retired");
		idx = expected[retired];
		assert (retirePacket.instr == trace[idx].instr)
			else failNow($sformatf("Mismatch retirePacket.instr: got %h expected %h",
				retirePacket.instr, trace[idx].instr));
		assert (retirePacket.pc == trace[idx].pc)
			else failNow($sformatf("Mismatch retirePacket.pc: got %h expected %h",
				retirePacket.pc, trace[idx].pc));
		assert (retirePacket.taken == trace[idx].taken)
			else failNow($sformatf("Mismatch retirePacket.taken: got %h expected %h",
				retirePacket.taken, trace[idx].taken));
		retireCycle[idx] = cycle;
		retired++;
		if (idx == TraceLen - 1) begin
			ecallCycle = cycle;
		end
	endtask

	// outputs settle after the rising edge, so they are read at the falling one
	task automatic sampleOutputs();
		if (creditReturn) begin
			credits++;
			returned++;
		end
		assert (credits <= FetchDepth)
			else failNow("the DUT returned more credits than packets it was sent");
		if (mispredict) begin
			redirects++;
		end
		if (ecallCycle >= 0) begin
			assert (!retireValid) else failNow("a packet retired after the ecall");
		end else if (retireValid) begin
			checkRetire();
		end
		if (ecallCycle >= 0) begin
			assert (halted) else failNow("halted is low after the ecall retired");
		end
	endtask

	// a packet is sent only with a credit in hand, and about one cycle in four idles
	task automatic driveInput();
		inValid = 1'b0;
		if (sent < TraceLen && credits > 0 && randBelow(4) != 0) begin
			inValid = 1'b1;
			inPacket = trace[sent];
			sent++;
			credits--;
		end
	endtask

	// a consumer right behind a load loses one cycle in the load-to-use stall
	task automatic checkStallGaps();
		logic dependent;
		for (int i = 0; i < TraceLen - 1; i++) begin
			dependent = traceLoad[i] && (traceRd[i] != 5'd0)
				&& (traceSrc1[i + 1] == traceRd[i] || traceSrc2[i + 1] == traceRd[i]);
			if (dependent && retireCycle[i] >= 0 && retireCycle[i + 1] >= 0) begin
				assert (retireCycle[i + 1] - retireCycle[i] >= 2)
					else failNow($sformatf("Mismatch retire gap after load at pc %h: got %h",
						trace[i].pc, retireCycle[i + 1] - retireCycle[i]));
			end
		end
	endtask

	initial begin
		inValid = 1'b0;
		inPacket = '0;
		lcgState = 32'd15;
		credits = FetchDepth;
		sent = 0;
		returned = 0;
		retired = 0;
		redirects = 0;
		cycle = 0;
		ecallCycle = -1;
		for (int i = 0; i < TraceLen; i++) begin
			retireCycle[i] = -1;
		end
		buildTrace();
		buildExpected();

		// the reset window and one cycle past it must stay idle
		do begin
			@(negedge clk);
			checkQuiet();
		end while (rst);
		@(negedge clk);
		checkQuiet();

		// run until the ecall retired and the quiet window behind it is over
		while (ecallCycle < 0 || cycle - ecallCycle <= QuietCycles) begin
			sampleOutputs();
			driveInput();
			@(negedge clk);
			cycle++;
			assert (cycle < CycleLimit)
				else failNow($sformatf("timeout: no halt within %0d cycles", CycleLimit));
		end

		assert (retired == expected.size())
			else failNow($sformatf("Mismatch retire count: got %h expected %h",
				retired, expected.size()));
		assert (redirects == expectedRedirects)
			else failNow($sformatf("Mismatch mispredict cycles: got %h expected %h",
				redirects, expectedRedirects));
		assert (sent == TraceLen)
			else failNow($sformatf("Mismatch inValid count: got %h expected %h", sent, TraceLen));
		// the ecall is the last packet, so nothing is left buffered once halted rises
		assert (returned == sent)
			else failNow($sformatf("Mismatch creditReturn count: got %h expected %h",
				returned, sent));
		checkStallGaps();

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
rtl/hazardPkg.sv
rtl/loadUseCheck.sv
rtl/controlUseCheck.sv
rtl/hazardDetection.sv
rtl/fetchBuffer.sv
rtl/pipelineTrack.sv
rtl/hazardTop.sv
verif/clockGen.sv
verif/tbHazard.sv

//--- run.sh
#!/usr/bin/env bash
# builds the hazard slice testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tbHazard -f list.f -o simHazard > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/simHazard > sim.log 2>&1
simStatus=$?

if grep -q "TEST FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi
if [ $simStatus -ne 0 ]; then
	echo "simulator exited with status $simStatus, see sim.log"
	exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi

echo "simulation passed"
exit 0
